// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_eth_wb_tx -f flist.f -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== eth_pkg.sv ====
//--------------------------------------------------------------------------
// Ethernet transmitter shared definitions
// Register map, bit positions, line timing and common types for the
// Wishbone 10BASE-T transmit core
//--------------------------------------------------------------------------
package eth_pkg;

    //----------------------------------------------------------------------
    // Types
    //----------------------------------------------------------------------
    typedef logic [7:0]  byte_t;       // Register or buffer byte
    typedef logic [15:0] wb_data_t;    // Wishbone data word
    typedef logic [10:0] buf_addr_t;   // Transmit buffer address
    typedef logic [2:0]  reg_idx_t;    // {wb_adr_i, wb_sel_i[1]}

    typedef enum logic [1:0] {
        TX_IDLE,                       // Waiting for FTSND
        TX_LOAD,                       // Address zeroed, waiting for first byte slot
        TX_SEND                        // Walking the buffer
    } tx_state_t;

    //----------------------------------------------------------------------
    // Register indexes, 4 to 7 are the absent receive side and read zero
    //----------------------------------------------------------------------
    localparam reg_idx_t REG_TX_STAT = 3'd0;   // FSENT, FTTX
    localparam reg_idx_t REG_TX_CNTL = 3'd1;   // FTSND, FTINT, A10..A8
    localparam reg_idx_t REG_TX_ADDR = 3'd2;   // A7..A0
    localparam reg_idx_t REG_TX_DATA = 3'd3;   // Byte at pointer

    // Status bits
    localparam int BIT_FSENT = 7;              // Frame sent, cleared by status write
    localparam int BIT_FTTX  = 6;              // Frame on the line

    // Control bits
    localparam int BIT_FTSND      = 7;         // Send request, self clearing
    localparam int BIT_FTINT      = 6;         // Interrupt enable
    localparam int CNTL_ADDR_BITS = 3;         // Low bits carry pointer bits 10..8

    //----------------------------------------------------------------------
    // Line timing in clk20 cycles
    //----------------------------------------------------------------------
    localparam int HALF_BITS_PER_BYTE = 16;    // Two half-bits per data bit
    localparam int IDLE_TAIL_CYCLES   = 6;     // High tail after the last bit
    localparam int LINK_PULSE_BITS    = 18;    // NLP every 2^18 idle cycles

endpackage

// ==== eth_tx_buffer.sv ====
//--------------------------------------------------------------------------
// Transmit frame store
// 2048 x 8 RAM, host read/write port and transmit read port, both with
// a registered read
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module eth_tx_buffer (
    input  logic                clk20,
    input  logic                wr_en_i,
    input  eth_pkg::buf_addr_t  host_addr_i,
    input  eth_pkg::byte_t      wr_data_i,
    input  eth_pkg::buf_addr_t  tx_addr_i,
    output eth_pkg::byte_t      host_data_o,
    output eth_pkg::byte_t      tx_data_o
);

    eth_pkg::byte_t mem [0:(1 << $bits(eth_pkg::buf_addr_t))-1];

    // Host port
    always_ff @(posedge clk20) begin
        if (wr_en_i)
            mem[host_addr_i] <= wr_data_i;
        host_data_o <= mem[host_addr_i];      // Old data on a write cycle
    end

    // Transmit port, read only
    always_ff @(posedge clk20) begin
        tx_data_o <= mem[tx_addr_i];
    end

endmodule

// ==== eth_tx_manchester.sv ====
//--------------------------------------------------------------------------
// 10BASE-T Manchester line driver
// Byte slot timing, LSB-first shifter and encoder, idle tail after the
// frame and the normal link pulse while idle
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module eth_tx_manchester (
    input  logic            clk20,
    input  logic            wb_rst_i,
    input  logic            sending_i,
    input  eth_pkg::byte_t  tx_byte_i,
    output logic            next_byte_o,
    output logic            ethernet_tx_o
);

    logic [$clog2(eth_pkg::HALF_BITS_PER_BYTE)-1:0] half_cnt;
    logic [$clog2(eth_pkg::IDLE_TAIL_CYCLES+1)-1:0] tail_cnt;
    logic [eth_pkg::LINK_PULSE_BITS-1:0]            lp_cnt;
    logic [1:0]                                     fetch_pipe;
    logic                                           load;
    logic                                           data_on;   // Shifter owns the line
    logic                                           run;
    logic                                           link_pulse;
    logic                                           idle_level;
    eth_pkg::byte_t                                 shift_q;

    //----------------------------------------------------------------------
    // Byte slots
    //----------------------------------------------------------------------
    // Slot request at count 15, byte arrives two cycles later (address
    // register plus RAM read), so the shifter loads at count 1
    assign next_byte_o = sending_i && (half_cnt == eth_pkg::HALF_BITS_PER_BYTE - 1);
    assign load        = fetch_pipe[1];
    assign run         = sending_i | data_on;   // Finish last byte after sending drops

    always_ff @(posedge clk20 or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            half_cnt   <= '1;
            fetch_pipe <= '0;
            data_on    <= 1'b0;
        end else begin
            half_cnt   <= run ? half_cnt + 1'b1 : '1;
            fetch_pipe <= {fetch_pipe[0] & sending_i, next_byte_o};  // No fetch after frame end
            if (load)
                data_on <= 1'b1;
            else if (half_cnt == 1)
                data_on <= 1'b0;                // Slot without a byte, frame over
        end
    end

    // Shift on every second half-bit
    always_ff @(posedge clk20) begin
        if (load)
            shift_q <= tx_byte_i;
        else if (half_cnt[0])
            shift_q <= shift_q >> 1;
    end

    //----------------------------------------------------------------------
    // Idle tail, link pulse and line register
    //----------------------------------------------------------------------
    assign link_pulse = &lp_cnt;
    assign idle_level = (tail_cnt < eth_pkg::IDLE_TAIL_CYCLES) | link_pulse;

    always_ff @(posedge clk20 or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            tail_cnt      <= $bits(tail_cnt)'(eth_pkg::IDLE_TAIL_CYCLES);  // No tail at power up
            lp_cnt        <= '0;
            ethernet_tx_o <= 1'b0;
        end else begin
            if (data_on)
                tail_cnt <= '0;
            else if (tail_cnt != eth_pkg::IDLE_TAIL_CYCLES)
                tail_cnt <= tail_cnt + 1'b1;

            lp_cnt <= run ? '0 : lp_cnt + 1'b1;   // Restart period after each frame

            // Even count drives the inverse bit, odd count the bit
            ethernet_tx_o <= data_on ? (shift_q[0] ^ ~half_cnt[0]) : idle_level;
        end
    end

endmodule

// ==== eth_tx_sequencer.sv ====
//--------------------------------------------------------------------------
// Transmit frame sequencer
// Walks the buffer read address from 0 to the last address, one step per
// byte slot, and flags the end of the frame
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module eth_tx_sequencer (
    input  logic                clk20,
    input  logic                wb_rst_i,
    input  logic                send_req_i,
    input  eth_pkg::buf_addr_t  last_addr_i,
    input  logic                next_byte_i,
    output eth_pkg::buf_addr_t  rd_addr_o,
    output logic                sending_o,
    output logic                frame_done_o
);

    eth_pkg::tx_state_t state;

    assign sending_o = (state != eth_pkg::TX_IDLE);   // FTTX, also runs the encoder

    always_ff @(posedge clk20 or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            state        <= eth_pkg::TX_IDLE;
            rd_addr_o    <= '0;
            frame_done_o <= 1'b0;
        end else begin
            frame_done_o <= 1'b0;
            case (state)
                eth_pkg::TX_IDLE: begin
                    if (send_req_i)
                        state <= eth_pkg::TX_LOAD;
                end
                // First slot fetches byte 0
                eth_pkg::TX_LOAD: begin
                    rd_addr_o <= '0;
                    if (next_byte_i)
                        state <= eth_pkg::TX_SEND;
                end
                eth_pkg::TX_SEND: begin
                    if (next_byte_i) begin
                        if (rd_addr_o == last_addr_i) begin
                            state        <= eth_pkg::TX_IDLE;   // Last byte already fetched
                            frame_done_o <= 1'b1;
                        end else begin
                            rd_addr_o <= rd_addr_o + 1'b1;     // Fetch following byte
                        end
                    end
                end
                default: state <= eth_pkg::TX_IDLE;
            endcase
        end
    end

    // Host pointer bounds the walk for the whole frame
    assert property (@(posedge clk20) disable iff (wb_rst_i)
        (state == eth_pkg::TX_SEND) |-> (rd_addr_o <= last_addr_i));

endmodule

// ==== eth_wb_regs.sv ====
//--------------------------------------------------------------------------
// Wishbone register block of the transmitter
// 16-bit classic slave with 8-bit registers on either byte lane. Holds
// control, pointer and frame-sent flag, drives buffer writes and the
// interrupt request
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module eth_wb_regs (
    input  logic                clk20,
    input  logic                wb_rst_i,
    input  eth_pkg::wb_data_t   wb_dat_i,
    output eth_pkg::wb_data_t   wb_dat_o,
    input  logic                wb_cyc_i,
    input  logic                wb_stb_i,
    input  logic [1:0]          wb_adr_i,
    input  logic [1:0]          wb_sel_i,
    input  logic                wb_we_i,
    output logic                wb_ack_o,
    output logic                wb_tgc_o,
    output logic                buf_wr_o,
    output eth_pkg::buf_addr_t  buf_addr_o,
    output eth_pkg::byte_t      buf_wdata_o,
    output logic                send_req_o,
    input  eth_pkg::byte_t      buf_rdata_i,
    input  logic                sending_i,
    input  logic                frame_done_i
);

    eth_pkg::reg_idx_t reg_idx;
    eth_pkg::byte_t    wr_byte;
    eth_pkg::byte_t    rd_mux;
    eth_pkg::byte_t    rd_byte;    // Read data held through the ack cycle
    eth_pkg::byte_t    tx_cntl;
    eth_pkg::byte_t    tx_addr;
    logic              access;
    logic              wr_access;
    logic              fsent;
    logic              sending_d;

    //----------------------------------------------------------------------
    // Bus decode
    //----------------------------------------------------------------------
    assign reg_idx   = {wb_adr_i, wb_sel_i[1]};
    assign wr_byte   = wb_sel_i[0] ? wb_dat_i[7:0] : wb_dat_i[15:8];
    assign access    = wb_cyc_i & wb_stb_i & ~wb_ack_o;   // First cycle only
    assign wr_access = access & wb_we_i;

    // Unused lane reads zero
    assign wb_dat_o = wb_sel_i[0] ? {8'h00, rd_byte} : {rd_byte, 8'h00};

    // Buffer store lands on the ack edge
    assign buf_wr_o    = wr_access && (reg_idx == eth_pkg::REG_TX_DATA);
    assign buf_wdata_o = wr_byte;
    assign buf_addr_o  = {tx_cntl[eth_pkg::CNTL_ADDR_BITS-1:0], tx_addr};

    assign send_req_o = tx_cntl[eth_pkg::BIT_FTSND];
    assign wb_tgc_o   = tx_cntl[eth_pkg::BIT_FTINT] & fsent;

    //----------------------------------------------------------------------
    // Read mux
    //----------------------------------------------------------------------
    always_comb begin
        rd_mux = '0;
        case (reg_idx)
            eth_pkg::REG_TX_STAT: begin
                rd_mux[eth_pkg::BIT_FSENT] = fsent;
                rd_mux[eth_pkg::BIT_FTTX]  = sending_i;
            end
            eth_pkg::REG_TX_CNTL: rd_mux = tx_cntl;
            eth_pkg::REG_TX_ADDR: rd_mux = tx_addr;
            eth_pkg::REG_TX_DATA: rd_mux = buf_rdata_i;    // Registered read at pointer
            default:              rd_mux = '0;             // Receive side absent
        endcase
    end

    always_ff @(posedge clk20) begin
        if (access)
            rd_byte <= rd_mux;
    end

    //----------------------------------------------------------------------
    // Ack and registers
    //----------------------------------------------------------------------
    always_ff @(posedge clk20 or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            wb_ack_o  <= 1'b0;
            tx_cntl   <= '0;
            tx_addr   <= '0;
            fsent     <= 1'b0;
            sending_d <= 1'b0;
        end else begin
            wb_ack_o  <= access;                // Single-cycle ack per transfer
            sending_d <= sending_i;

            // Request taken by the sequencer
            if (sending_i && !sending_d)
                tx_cntl[eth_pkg::BIT_FTSND] <= 1'b0;

            if (wr_access) begin
                case (reg_idx)
                    eth_pkg::REG_TX_STAT: fsent   <= 1'b0;     // Any value clears
                    eth_pkg::REG_TX_CNTL: tx_cntl <= wr_byte;
                    eth_pkg::REG_TX_ADDR: tx_addr <= wr_byte;
                    default: ;                                  // Data goes to buffer
                endcase
            end

            if (frame_done_i)
                fsent <= 1'b1;                  // Completion wins over a clear
        end
    end

    // Frame completion arrives only as the sequencer leaves the frame
    assert property (@(posedge clk20) disable iff (wb_rst_i)
        frame_done_i |-> (!sending_i && $past(sending_i)));

endmodule

// ==== eth_wb_tx.sv ====
//--------------------------------------------------------------------------
// Wishbone 10BASE-T transmitter top
// Register block, frame store, sequencer and Manchester driver on clk20
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module eth_wb_tx (
    input  logic               clk20,
    input  logic               wb_rst_i,
    input  eth_pkg::wb_data_t  wb_dat_i,
    output eth_pkg::wb_data_t  wb_dat_o,
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic [1:0]         wb_adr_i,
    input  logic [1:0]         wb_sel_i,
    input  logic               wb_we_i,
    output logic               wb_ack_o,
    output logic               wb_tgc_o,
    output logic               ethernet_tx_o
);

    logic               buf_wr;
    eth_pkg::buf_addr_t buf_addr;    // Host pointer and last frame address
    eth_pkg::byte_t     buf_wdata;
    eth_pkg::byte_t     buf_rdata;
    eth_pkg::buf_addr_t rd_addr;
    eth_pkg::byte_t     tx_byte;
    logic               send_req;
    logic               sending;
    logic               frame_done;
    logic               next_byte;

    eth_wb_regs u_regs (
        .clk20        (clk20),
        .wb_rst_i     (wb_rst_i),
        .wb_dat_i     (wb_dat_i),
        .wb_dat_o     (wb_dat_o),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_adr_i     (wb_adr_i),
        .wb_sel_i     (wb_sel_i),
        .wb_we_i      (wb_we_i),
        .wb_ack_o     (wb_ack_o),
        .wb_tgc_o     (wb_tgc_o),
        .buf_wr_o     (buf_wr),
        .buf_addr_o   (buf_addr),
        .buf_wdata_o  (buf_wdata),
        .send_req_o   (send_req),
        .buf_rdata_i  (buf_rdata),
        .sending_i    (sending),
        .frame_done_i (frame_done)
    );

    eth_tx_buffer u_buffer (
        .clk20       (clk20),
        .wr_en_i     (buf_wr),
        .host_addr_i (buf_addr),
        .wr_data_i   (buf_wdata),
        .tx_addr_i   (rd_addr),
        .host_data_o (buf_rdata),
        .tx_data_o   (tx_byte)
    );

    eth_tx_sequencer u_sequencer (
        .clk20        (clk20),
        .wb_rst_i     (wb_rst_i),
        .send_req_i   (send_req),
        .last_addr_i  (buf_addr),
        .next_byte_i  (next_byte),
        .rd_addr_o    (rd_addr),
        .sending_o    (sending),
        .frame_done_o (frame_done)
    );

    eth_tx_manchester u_manchester (
        .clk20         (clk20),
        .wb_rst_i      (wb_rst_i),
        .sending_i     (sending),
        .tx_byte_i     (tx_byte),
        .next_byte_o   (next_byte),
        .ethernet_tx_o (ethernet_tx_o)
    );

endmodule

// ==== flist.f ====
eth_pkg.sv
eth_wb_regs.sv
eth_tx_buffer.sv
eth_tx_sequencer.sv
eth_tx_manchester.sv
eth_wb_tx.sv
tb_eth_wb_tx.sv

// ==== tb_eth_wb_tx.sv ====
//--------------------------------------------------------------------------
// Transmitter testbench
// Register reset values, buffer read-back on both lanes, line decode of
// whole frames, status and interrupt flags, idle link pulse
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_eth_wb_tx;

    localparam int BUS_TIMEOUT  = 8;        // Cycles for an ack
    localparam int EDGE_TIMEOUT = 200;      // FTSND write to first line edge
    localparam int POLL_LIMIT   = 40;       // Status reads while a frame runs
    localparam int LINK_TIMEOUT = (1 << eth_pkg::LINK_PULSE_BITS) + 16;

    logic              clk20;
    logic              wb_rst_i;
    eth_pkg::wb_data_t wb_dat_i;
    eth_pkg::wb_data_t wb_dat_o;
    logic              wb_cyc_i;
    logic              wb_stb_i;
    logic [1:0]        wb_adr_i;
    logic [1:0]        wb_sel_i;
    logic              wb_we_i;
    logic              wb_ack_o;
    logic              wb_tgc_o;
    logic              ethernet_tx_o;

    int                checks;
    int                errors;
    int                timeouts;
    bit                saw_fttx;              // FTTX read high during the frame
    eth_pkg::byte_t    tx_frame [0:15];       // Bytes loaded into the buffer
    eth_pkg::byte_t    rx_frame [0:15];       // Bytes rebuilt from the line

    eth_wb_tx u_eth_wb_tx (
        .clk20         (clk20),
        .wb_rst_i      (wb_rst_i),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_adr_i      (wb_adr_i),
        .wb_sel_i      (wb_sel_i),
        .wb_we_i       (wb_we_i),
        .wb_ack_o      (wb_ack_o),
        .wb_tgc_o      (wb_tgc_o),
        .ethernet_tx_o (ethernet_tx_o)
    );

    initial begin
        clk20 = 1'b0;
        forever #2 clk20 = ~clk20;            // 4 ns period
    end

    //----------------------------------------------------------------------
    // Checking and bus access
    //----------------------------------------------------------------------
    task automatic expect_equal(input string what, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timed out at %0t ns while waiting for %s", $time, what);
    endtask

    // One classic cycle, inputs change on the falling edge
    task automatic bus_cycle(input eth_pkg::reg_idx_t idx, input bit lane_lo, input bit we,
                             input eth_pkg::wb_data_t wdata, output eth_pkg::wb_data_t rdata);
        int waited;
        @(negedge clk20);
        wb_adr_i = idx[2:1];
        wb_sel_i = {idx[0], lane_lo};         // Bit 1 picks the register, bit 0 the lane
        wb_we_i  = we;
        wb_dat_i = wdata;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        waited   = 0;
        do begin
            @(negedge clk20);
            waited++;
        end while (!wb_ack_o && waited < BUS_TIMEOUT);
        rdata = wb_dat_o;                     // Valid while ack is high
        if (!wb_ack_o)
            report_timeout("Wishbone ack");
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic wb_write(input eth_pkg::reg_idx_t idx, input bit lane_lo,
                            input eth_pkg::byte_t b);
        eth_pkg::wb_data_t unused;
        bus_cycle(idx, lane_lo, 1'b1, lane_lo ? {8'h00, b} : {b, 8'h00}, unused);
    endtask

    task automatic wb_read(input eth_pkg::reg_idx_t idx, input bit lane_lo,
                           output eth_pkg::wb_data_t word);
        bus_cycle(idx, lane_lo, 1'b0, '0, word);
    endtask

    task automatic set_pointer(input eth_pkg::buf_addr_t addr);
        wb_write(eth_pkg::REG_TX_CNTL, 1'b1, {5'b00000, addr[10:8]});
        wb_write(eth_pkg::REG_TX_ADDR, 1'b1, addr[7:0]);
    endtask

    //----------------------------------------------------------------------
    // Line decoder, first rising edge is the second half of bit 0
    //----------------------------------------------------------------------
    task automatic decode_frame(input int n);
        int   waited;
        int   k;
        logic prev;
        bit   found;
        prev  = 1'b1;
        found = 1'b0;
        for (waited = 0; waited < EDGE_TIMEOUT && !found; waited++) begin
            @(negedge clk20);
            found = ethernet_tx_o && !prev;
            prev  = ethernet_tx_o;
        end
        if (!found) begin
            report_timeout("the first rising edge of a frame");
            return;
        end
        for (k = 0; k < n * 8; k++) begin
            if (k > 0)
                repeat (2) @(negedge clk20);  // Second half carries the bit
            rx_frame[k / 8][k % 8] = ethernet_tx_o;
        end
        for (k = 0; k < eth_pkg::IDLE_TAIL_CYCLES; k++) begin
            @(negedge clk20);
            expect_equal("idle tail level", ethernet_tx_o, 1);
        end
        @(negedge clk20);
        expect_equal("line after idle tail", ethernet_tx_o, 0);
    endtask

    // Load n bytes, start the frame and decode it while polling FTTX
    task automatic run_frame(input int n, input bit ftint);
        eth_pkg::wb_data_t word;
        int                i;
        wb_write(eth_pkg::REG_TX_STAT, 1'b1, 8'h00);   // FSENT from a previous frame
        tx_frame[0] = 8'h55;
        for (i = 1; i < n; i++)
            tx_frame[i] = eth_pkg::byte_t'($urandom);
        for (i = 0; i < n; i++) begin
            wb_write(eth_pkg::REG_TX_ADDR, 1'b1, eth_pkg::byte_t'(i));
            wb_write(eth_pkg::REG_TX_DATA, 1'b1, tx_frame[i]);
        end
        wb_write(eth_pkg::REG_TX_ADDR, 1'b1, eth_pkg::byte_t'(n - 1));   // Last address
        saw_fttx = 1'b0;
        fork
            decode_frame(n);
            begin
                wb_write(eth_pkg::REG_TX_CNTL, 1'b1, {1'b1, ftint, 6'b000000});
                for (i = 0; i < POLL_LIMIT && !saw_fttx; i++) begin
                    wb_read(eth_pkg::REG_TX_STAT, 1'b1, word);
                    saw_fttx = word[eth_pkg::BIT_FTTX];
                end
            end
        join
        for (i = 0; i < n; i++)
            expect_equal($sformatf("frame byte %0d", i), rx_frame[i], tx_frame[i]);
    endtask

    //----------------------------------------------------------------------
    // Tests
    //----------------------------------------------------------------------
    task automatic test_reset_state();
        eth_pkg::wb_data_t word;
        expect_equal("ack after reset", wb_ack_o, 0);
        expect_equal("interrupt after reset", wb_tgc_o, 0);
        expect_equal("line after reset", ethernet_tx_o, 0);
        for (int idx = 0; idx < 8; idx++) begin
            if (idx != eth_pkg::REG_TX_DATA) begin         // Buffer contents undefined
                wb_read(eth_pkg::reg_idx_t'(idx), 1'b1, word);
                expect_equal($sformatf("register %0d after reset", idx), word, 0);
            end
        end
    endtask

    task automatic test_buffer_readback();
        eth_pkg::wb_data_t  word;
        eth_pkg::buf_addr_t addr [0:7];
        eth_pkg::byte_t     data [0:7];
        eth_pkg::buf_addr_t base;
        base = eth_pkg::buf_addr_t'($urandom);
        for (int i = 0; i < 8; i++) begin
            addr[i] = eth_pkg::buf_addr_t'(base + i * 257);   // Distinct, upper bits vary
            data[i] = eth_pkg::byte_t'($urandom);
            set_pointer(addr[i]);
            wb_write(eth_pkg::REG_TX_DATA, i[0], data[i]);
        end
        for (int i = 0; i < 8; i++) begin
            set_pointer(addr[i]);
            wb_read(eth_pkg::REG_TX_DATA, 1'b1, word);
            expect_equal("buffer byte on low lane", word, {8'h00, data[i]});
            wb_read(eth_pkg::REG_TX_DATA, 1'b0, word);
            expect_equal("buffer byte on high lane", word, {data[i], 8'h00});
        end
        wb_write(eth_pkg::REG_TX_CNTL, 1'b1, 8'h00);
    endtask

    task automatic test_frame_encoding();
        run_frame(12, 1'b0);
    endtask

    task automatic test_status_irq(input bit ftint);
        eth_pkg::wb_data_t word;
        run_frame(4, ftint);
        expect_equal("FTTX during frame", saw_fttx, 1);
        wb_read(eth_pkg::REG_TX_STAT, 1'b1, word);
        expect_equal("status after frame", word, 16'h0080);
        expect_equal("interrupt after frame", wb_tgc_o, ftint);
        wb_read(eth_pkg::REG_TX_CNTL, 1'b1, word);
        expect_equal("control after frame", word, {8'h00, 1'b0, ftint, 6'b000000});
        wb_write(eth_pkg::REG_TX_STAT, 1'b1, eth_pkg::byte_t'($urandom));
        wb_read(eth_pkg::REG_TX_STAT, 1'b1, word);
        expect_equal("status after clear", word, 0);
        expect_equal("interrupt after clear", wb_tgc_o, 0);
    endtask

    task automatic test_link_pulse();
        bit found;
        found = 1'b0;
        for (int waited = 0; waited < LINK_TIMEOUT && !found; waited++) begin
            @(negedge clk20);
            found = ethernet_tx_o;
        end
        if (!found) begin
            report_timeout("a link pulse");
        end else begin
            @(negedge clk20);
            expect_equal("line after link pulse", ethernet_tx_o, 0);   // One cycle wide
        end
    endtask

    initial begin
        checks   = 0;
        errors   = 0;
        timeouts = 0;
        void'($urandom(32'h3798));
        wb_rst_i = 1'b1;
        wb_dat_i = '0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_adr_i = '0;
        wb_sel_i = '0;
        wb_we_i  = 1'b0;
        repeat (4) @(negedge clk20);
        wb_rst_i = 1'b0;
        test_reset_state();
        test_buffer_readback();
        test_frame_encoding();
        test_status_irq(1'b0);
        test_status_irq(1'b1);
        test_link_pulse();
        $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule
